// ==== verilog/geomPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// field geometry shared by the obstacles and the player
////////////////////////////////////////////////////////////////////////////

package geomPkg;

    // pixel coordinate, wide enough for 640 plus an object size
    typedef logic [10:0] coord_t;

    // object color, compared between player and rectangle
    typedef logic [3:0] color_t;

    // visible field
    parameter coord_t FIELD_W = 11'd640;   // columns
    parameter coord_t FIELD_H = 11'd480;   // rows

    // player is a square of this side
    parameter coord_t PLAYER_SIZE = 11'd12;

    // positions are always the top-left corner of an object,
    // so the far edges are corner plus size

    // the player can sit anywhere with its whole square on the field,
    // rectangles wrap and may start at any corner within the field

    // all widths are kept at coord_t so edge sums need no extension

endpackage

// ==== verilog/ctrlPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// button codes and the direction flag layout
////////////////////////////////////////////////////////////////////////////

package ctrlPkg;

    typedef logic [3:0] btn_t;      // {up, down, right, left}

    // one-hot press codes, anything else is no press
    parameter btn_t BTN_UP    = 4'd8;
    parameter btn_t BTN_DOWN  = 4'd4;
    parameter btn_t BTN_RIGHT = 4'd2;
    parameter btn_t BTN_LEFT  = 4'd1;

    // block flags, same bit order as the buttons
    typedef logic [3:0] dirFlags_t;

endpackage

// ==== verilog/rectIf.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// one rectangle's link to the player logic
////////////////////////////////////////////////////////////////////////////

interface rectIf;

    geomPkg::coord_t rectH;         // rectangle top-left, column
    geomPkg::coord_t rectV;         // rectangle top-left, row
    ctrlPkg::dirFlags_t block;      // player moves this rectangle stops
    geomPkg::coord_t playerH;       // player top-left, column
    geomPkg::coord_t playerV;       // player top-left, row

    // rectangle side
    modport obstacle (
        output rectH,
        output rectV,
        output block,
        input  playerH,
        input  playerV
    );

    // player side
    modport mover (
        input  rectH,
        input  rectV,
        input  block,
        output playerH,
        output playerV
    );

endinterface

// ==== verilog/btnSync.sv ====
`timescale 1ns/1ps

module btnSync (
    input  logic          btnClk,
    input  logic          rst,
    input  ctrlPkg::btn_t btns_i,
    input  logic          rectMode_i,
    output ctrlPkg::btn_t rectBtns_o,
    output ctrlPkg::btn_t playerBtns_o
);

    ctrlPkg::btn_t btnsMeta;    // first stage, may be metastable
    logic          modeMeta;
    ctrlPkg::btn_t cleanPress;  // one-hot or zero

    // only a single button down counts
    always_comb
    begin
        case (btnsMeta)
            ctrlPkg::BTN_UP,
            ctrlPkg::BTN_DOWN,
            ctrlPkg::BTN_RIGHT,
            ctrlPkg::BTN_LEFT: cleanPress = btnsMeta;
            default:           cleanPress = '0;   // chord or idle
        endcase
    end

    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            btnsMeta     <= '0;
            modeMeta     <= 1'b0;
            rectBtns_o   <= '0;
            playerBtns_o <= '0;
        end
        else
        begin
            btnsMeta     <= btns_i;      // stage 1
            modeMeta     <= rectMode_i;
            // stage 2, steer by mode, other bus idle
            rectBtns_o   <= modeMeta ? cleanPress : '0;
            playerBtns_o <= modeMeta ? '0 : cleanPress;
        end
    end

endmodule

// ==== verilog/rectangle.sv ====
`timescale 1ns/1ps

module rectangle #(
    parameter geomPkg::coord_t START_H    = 11'd0,
    parameter geomPkg::coord_t START_V    = 11'd0,
    parameter geomPkg::coord_t WIDTH      = 11'd16,
    parameter geomPkg::coord_t HEIGHT     = 11'd16,
    parameter geomPkg::color_t RECT_COLOR = 4'd0
) (
    input  logic            btnClk,
    input  logic            rst,
    input  ctrlPkg::btn_t   btns_i,
    input  logic            visible_i,
    input  geomPkg::color_t playerColor_i,
    rectIf.obstacle         rectBus
);

    geomPkg::coord_t    rectH;      // top-left corner, absolute
    geomPkg::coord_t    rectV;
    ctrlPkg::dirFlags_t blockQ;     // registered flags

    // edges of both objects
    geomPkg::coord_t    rectRight;
    geomPkg::coord_t    rectBottom;
    geomPkg::coord_t    playerRight;
    geomPkg::coord_t    playerBottom;

    logic               hOverlap;
    logic               vOverlap;
    logic               solid;      // visible and other color
    ctrlPkg::dirFlags_t blockNext;

    ////////////////////////////////////////////////////////////////////////////
    // movement with wrap at every field edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            rectH <= START_H;
            rectV <= START_V;
        end
        else
        begin
            case (btns_i)
                ctrlPkg::BTN_UP:
                begin
                    if (rectV > 11'd0)
                        rectV <= rectV - 11'd1;
                    else
                        rectV <= geomPkg::FIELD_H - HEIGHT;   // reappear at bottom
                end
                ctrlPkg::BTN_DOWN:
                begin
                    if (rectBottom < geomPkg::FIELD_H)
                        rectV <= rectV + 11'd1;
                    else
                        rectV <= 11'd0;                       // back to top
                end
                ctrlPkg::BTN_RIGHT:
                begin
                    if (rectRight < geomPkg::FIELD_W)
                        rectH <= rectH + 11'd1;
                    else
                        rectH <= 11'd0;
                end
                ctrlPkg::BTN_LEFT:
                begin
                    if (rectH > 11'd0)
                        rectH <= rectH - 11'd1;
                    else
                        rectH <= geomPkg::FIELD_W - WIDTH;
                end
                default: ;  // no press, hold
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // adjacency test against the player
    ////////////////////////////////////////////////////////////////////////////

    assign rectRight    = rectH + WIDTH;
    assign rectBottom   = rectV + HEIGHT;
    assign playerRight  = rectBus.playerH + geomPkg::PLAYER_SIZE;
    assign playerBottom = rectBus.playerV + geomPkg::PLAYER_SIZE;

    // open intervals, touching corners do not count
    assign hOverlap = (rectBus.playerH < rectRight) && (playerRight > rectH);
    assign vOverlap = (rectBus.playerV < rectBottom) && (playerBottom > rectV);

    assign solid = visible_i && (playerColor_i != RECT_COLOR);

    always_comb
    begin
        blockNext = '0;
        if (solid)
        begin
            if (playerBottom == rectV && hOverlap)         // sitting on top
                blockNext = blockNext | ctrlPkg::BTN_DOWN;
            if (rectBus.playerV == rectBottom && hOverlap) // just below
                blockNext = blockNext | ctrlPkg::BTN_UP;
            if (playerRight == rectH && vOverlap)          // left of it
                blockNext = blockNext | ctrlPkg::BTN_RIGHT;
            if (rectBus.playerH == rectRight && vOverlap)  // right of it
                blockNext = blockNext | ctrlPkg::BTN_LEFT;
        end
    end

    // one cycle behind the positions
    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
            blockQ <= '0;
        else
            blockQ <= blockNext;
    end

    assign rectBus.rectH = rectH;
    assign rectBus.rectV = rectV;
    assign rectBus.block = blockQ;

endmodule

// ==== verilog/playerMover.sv ====
`timescale 1ns/1ps

module playerMover (
    input  logic               btnClk,
    input  logic               rst,
    input  ctrlPkg::btn_t      btns_i,
    rectIf.mover               rect0,
    rectIf.mover               rect1,
    output ctrlPkg::dirFlags_t blocked_o
);

    geomPkg::coord_t playerH;       // top-left corner
    geomPkg::coord_t playerV;
    ctrlPkg::btn_t   allowed;       // press left after blocking

    // any rectangle can stop a move
    assign blocked_o = rect0.block | rect1.block;

    // flags share the button bit order
    assign allowed = btns_i & ~blocked_o;

    ////////////////////////////////////////////////////////////////////////////
    // position, clamped so the whole square stays on the field
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            playerH <= 11'd0;
            playerV <= 11'd0;
        end
        else
        begin
            case (allowed)
                ctrlPkg::BTN_UP:
                    if (playerV > 11'd0)
                        playerV <= playerV - 11'd1;
                ctrlPkg::BTN_DOWN:
                    if (playerV < geomPkg::FIELD_H - geomPkg::PLAYER_SIZE)
                        playerV <= playerV + 11'd1;
                ctrlPkg::BTN_RIGHT:
                    if (playerH < geomPkg::FIELD_W - geomPkg::PLAYER_SIZE)
                        playerH <= playerH + 11'd1;
                ctrlPkg::BTN_LEFT:
                    if (playerH > 11'd0)
                        playerH <= playerH - 11'd1;
                default: ;  // idle or blocked
            endcase
        end
    end

    // both rectangles test against the same square
    assign rect0.playerH = playerH;
    assign rect0.playerV = playerV;
    assign rect1.playerH = playerH;
    assign rect1.playerV = playerV;

endmodule

// ==== verilog/colorGameTop.sv ====
`timescale 1ns/1ps

module colorGameTop #(
    parameter geomPkg::coord_t RECT0_START_H = 11'd100,
    parameter geomPkg::coord_t RECT0_START_V = 11'd200,
    parameter geomPkg::coord_t RECT0_WIDTH   = 11'd60,
    parameter geomPkg::coord_t RECT0_HEIGHT  = 11'd40,
    parameter geomPkg::color_t RECT0_COLOR   = 4'd3,
    parameter geomPkg::coord_t RECT1_START_H = 11'd300,
    parameter geomPkg::coord_t RECT1_START_V = 11'd24,
    parameter geomPkg::coord_t RECT1_WIDTH   = 11'd40,
    parameter geomPkg::coord_t RECT1_HEIGHT  = 11'd80,
    parameter geomPkg::color_t RECT1_COLOR   = 4'd5
) (
    input  logic               btnClk,
    input  logic               rst,
    input  ctrlPkg::btn_t      btns_i,
    input  logic               rectMode_i,     // 1 moves rectangles
    input  logic               visible_i,
    input  geomPkg::color_t    playerColor_i,
    output geomPkg::coord_t    playerH_o,
    output geomPkg::coord_t    playerV_o,
    output geomPkg::coord_t    rect0H_o,
    output geomPkg::coord_t    rect0V_o,
    output geomPkg::coord_t    rect1H_o,
    output geomPkg::coord_t    rect1V_o,
    output ctrlPkg::dirFlags_t blocked_o
);

    ctrlPkg::btn_t rectBtns;    // both rectangles
    ctrlPkg::btn_t playerBtns;

    rectIf rect0Bus ();
    rectIf rect1Bus ();

    btnSync sync0 (
        .btnClk       (btnClk),
        .rst          (rst),
        .btns_i       (btns_i),
        .rectMode_i   (rectMode_i),
        .rectBtns_o   (rectBtns),
        .playerBtns_o (playerBtns)
    );

    ////////////////////////////////////////////////////////////////////////////
    // obstacles
    ////////////////////////////////////////////////////////////////////////////

    rectangle #(
        .START_H    (RECT0_START_H),
        .START_V    (RECT0_START_V),
        .WIDTH      (RECT0_WIDTH),
        .HEIGHT     (RECT0_HEIGHT),
        .RECT_COLOR (RECT0_COLOR)
    ) rect0 (
        .btnClk        (btnClk),
        .rst           (rst),
        .btns_i        (rectBtns),
        .visible_i     (visible_i),
        .playerColor_i (playerColor_i),
        .rectBus       (rect0Bus.obstacle)
    );

    rectangle #(
        .START_H    (RECT1_START_H),
        .START_V    (RECT1_START_V),
        .WIDTH      (RECT1_WIDTH),
        .HEIGHT     (RECT1_HEIGHT),
        .RECT_COLOR (RECT1_COLOR)
    ) rect1 (
        .btnClk        (btnClk),
        .rst           (rst),
        .btns_i        (rectBtns),
        .visible_i     (visible_i),
        .playerColor_i (playerColor_i),
        .rectBus       (rect1Bus.obstacle)
    );

    playerMover mover0 (
        .btnClk    (btnClk),
        .rst       (rst),
        .btns_i    (playerBtns),
        .rect0     (rect0Bus.mover),
        .rect1     (rect1Bus.mover),
        .blocked_o (blocked_o)
    );

    // positions straight from the registers behind the buses
    assign playerH_o = rect0Bus.playerH;
    assign playerV_o = rect0Bus.playerV;
    assign rect0H_o  = rect0Bus.rectH;
    assign rect0V_o  = rect0Bus.rectV;
    assign rect1H_o  = rect1Bus.rectH;
    assign rect1V_o  = rect1Bus.rectV;

endmodule

// ==== verif/colorGameTb.sv ====
`timescale 1ns/1ps

module colorGameTb;

    localparam int CLK_HALF     = 10;   // 20 ns clock
    localparam int DRIVE_DELAY  = 2;    // inputs change just after the rising edge
    localparam int RESET_CYCLES = 4;
    localparam int SLACK_CYCLES = 20;   // margin over one cycle per vector

    // same names as the DUT ports, hooked up by .*
    logic               btnClk;
    logic               rst;
    ctrlPkg::btn_t      btns_i;
    logic               rectMode_i;
    logic               visible_i;
    geomPkg::color_t    playerColor_i;
    geomPkg::coord_t    playerH_o;
    geomPkg::coord_t    playerV_o;
    geomPkg::coord_t    rect0H_o;
    geomPkg::coord_t    rect0V_o;
    geomPkg::coord_t    rect1H_o;
    geomPkg::coord_t    rect1V_o;
    ctrlPkg::dirFlags_t blocked_o;

    string vectorQ[$];      // raw lines of the stimulus file
    int    cycleCount;
    int    cycleLimit;      // stays 0 until the file is read

    // obstacles next to the start corner, so each edge case is a short walk
    colorGameTop #(
        .RECT0_START_H (11'd4),     // player touches its top at V=4
        .RECT0_START_V (11'd16),
        .RECT1_START_V (11'd0)      // sits at the top, next up press wraps
    ) dut0 (.*);

    initial
    begin
        btnClk = 1'b0;
        forever #CLK_HALF btnClk = ~btnClk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // vector handling
    ////////////////////////////////////////////////////////////////////////////

    task automatic compareValue(input string testName, input string sigName,
                                input logic [10:0] expected, input logic [10:0] actual);
        if (actual !== expected)    // x or z counts as a miss
        begin
            $display("Error: test %s, %s expected %0h, actual %0h",
                     testName, sigName, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic loadVectors;
        int    fd;
        string text;
        fd = $fopen("verif/colorGameStimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file verif/colorGameStimulus.txt");
            $display("*** TEST FAILED ***");
            $fatal(1, "no stimulus");
        end
        else
        begin
            while ($fgets(text, fd) != 0)
            begin
                if (text.len() > 1 && text.getc(0) != "#")   // skip notes, blanks
                    vectorQ.push_back(text);
            end
            $fclose(fd);
        end
    endtask

    // one vector is one clock, outputs checked mid cycle
    task automatic applyVector(input string text);
        string       testName;
        logic [31:0] inBtns, inMode, inVis, inColor;
        logic [31:0] expPH, expPV, expR0H, expR0V, expR1H, expR1V, expBlk;
        int          fields;
        fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h", testName,
                         inBtns, inMode, inVis, inColor, expPH, expPV,
                         expR0H, expR0V, expR1H, expR1V, expBlk);
        if (fields != 12)
        begin
            $display("A stimulus line has the wrong number of columns: %s", text);
            $display("*** TEST FAILED ***");
            $fatal(1, "bad stimulus line");
        end
        else
        begin
            @(posedge btnClk);
            #DRIVE_DELAY;
            btns_i        = inBtns[3:0];
            rectMode_i    = inMode[0];
            visible_i     = inVis[0];
            playerColor_i = inColor[3:0];
            @(negedge btnClk);      // state of the last rising edge
            compareValue(testName, "playerH", expPH[10:0], playerH_o);
            compareValue(testName, "playerV", expPV[10:0], playerV_o);
            compareValue(testName, "rect0H", expR0H[10:0], rect0H_o);
            compareValue(testName, "rect0V", expR0V[10:0], rect0V_o);
            compareValue(testName, "rect1H", expR1H[10:0], rect1H_o);
            compareValue(testName, "rect1V", expR1V[10:0], rect1V_o);
            compareValue(testName, "blocked", {7'd0, expBlk[3:0]}, {7'd0, blocked_o});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        rst           = 1'b1;
        btns_i        = '0;    // idle, no press
        rectMode_i    = 1'b0;
        visible_i     = 1'b1;
        playerColor_i = '0;
        loadVectors();
        cycleLimit = vectorQ.size() + RESET_CYCLES + SLACK_CYCLES;
        repeat (RESET_CYCLES) @(posedge btnClk);
        #DRIVE_DELAY;
        rst = 1'b0;
        foreach (vectorQ[i])
            applyVector(vectorQ[i]);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial
    begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit)
        begin
            @(posedge btnClk);
            cycleCount = cycleCount + 1;
        end
        $display("The run went %0d cycles without reaching the last vector", cycleCount);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

// ==== colorGameTop.f ====
verilog/geomPkg.sv
verilog/ctrlPkg.sv
verilog/rectIf.sv
verilog/btnSync.sv
verilog/rectangle.sv
verilog/playerMover.sv
verilog/colorGameTop.sv
verif/colorGameTb.sv

// ==== verif/colorGameStimulus.txt ====
# name btns rectMode visible playerColor, then expected playerH playerV rect0H rect0V rect1H rect1V blocked
# all hex, one line per clock, a press driven on a line shows in the positions three lines later
clampLeft   1 0 1 0   0 0 4 10 12c   0 0
clampLeft   1 0 1 0   0 0 4 10 12c   0 0
moveRight   2 0 1 0   0 0 4 10 12c   0 0
moveRight   2 0 1 0   0 0 4 10 12c   0 0
moveRight   2 0 1 0   0 0 4 10 12c   0 0
moveDown    4 0 1 0   1 0 4 10 12c   0 0
moveDown    4 0 1 0   2 0 4 10 12c   0 0
moveDown    4 0 1 0   3 0 4 10 12c   0 0
moveDown    4 0 1 0   3 1 4 10 12c   0 0
settle      0 0 1 0   3 2 4 10 12c   0 0
blockDown   4 0 1 0   3 3 4 10 12c   0 0
blockDown   4 0 1 0   3 4 4 10 12c   0 0
blockDown   4 0 1 0   3 4 4 10 12c   0 4
blockDown   0 0 1 0   3 4 4 10 12c   0 4
hideRects   0 0 0 0   3 4 4 10 12c   0 4
hideRects   0 0 0 0   3 4 4 10 12c   0 0
showRects   0 0 1 0   3 4 4 10 12c   0 0
sameColor   4 0 1 3   3 4 4 10 12c   0 4
sameColor   4 0 1 3   3 4 4 10 12c   0 0
sameColor   0 0 1 3   3 4 4 10 12c   0 0
sameColor   0 0 1 3   3 5 4 10 12c   0 0
chordPress  3 0 1 3   3 6 4 10 12c   0 0
chordPress  f 0 1 0   3 6 4 10 12c   0 0
rectUp      8 1 1 0   3 6 4 10 12c   0 0
rectUp      8 1 1 0   3 6 4 10 12c   0 0
rectUp      0 1 1 0   3 6 4 10 12c   0 0
rectWrap    1 0 1 0   3 6 4  f 12c 190 0
rectWrap    0 0 1 0   3 6 4  e 12c 18f 0
moveLeft    0 0 1 0   3 6 4  e 12c 18f 0
moveLeft    0 0 1 0   2 6 4  e 12c 18f 0
